// File: source/alu_ext_config.svh
// width and iteration constants for the external ALU, included by the package and the RTL
`ifndef ALU_EXT_CONFIG_SVH
`define ALU_EXT_CONFIG_SVH

`define ALU_DW       32          // data width
`define ALU_SW       5           // shift amount width, log2 of data width

// one quotient bit per iteration
`define ALU_DIV_ITER `ALU_DW

`endif

// File: source/alu_ext_pkg.sv
// shared types of the external ALU: data words, shift amounts, opcodes and CSR addresses
`include "alu_ext_config.svh"

package alu_ext_pkg;

    typedef logic [`ALU_DW-1:0] data_t;     // operand or result word
    typedef logic [`ALU_SW-1:0] shamt_t;    // low bits of operand b

    // request opcode
    typedef enum logic [1:0] {
        OP_SHL = 2'd0,                      // shift left
        OP_SHR = 2'd1,                      // shift right, mode from CSR
        OP_MUL = 2'd2,                      // unsigned 32x32
        OP_DIV = 2'd3                       // unsigned 32/32
    } alu_op_e;

    // register port addresses
    typedef enum logic [1:0] {
        CSR_CTRL   = 2'd0,                  // bit 0 shift_arith
        CSR_COUNT  = 2'd1,                  // delivered results, read only
        CSR_STATUS = 2'd2                   // bit 0 sticky div by zero
    } csr_addr_e;

endpackage

// File: source/alu_shift_unit.sv
// combinational barrel shifter steered for left, logical right and arithmetic right shifts
`timescale 1ns/1ps
`include "alu_ext_config.svh"

module alu_shift_unit (
    input  alu_ext_pkg::data_t  d,
    input  alu_ext_pkg::shamt_t amount,
    input  logic                left,
    input  logic                arith,
    output alu_ext_pkg::data_t  r
);
    import alu_ext_pkg::*;

    localparam data_t ONES = '1;

    logic  fill;                            // bit shifted in from the top
    data_t src;                             // input, reversed for left shifts
    data_t sh;                              // right shift core

    always_comb begin
        fill = arith && !left && d[`ALU_DW-1];  // sign fill only on arith right
        for (int i = 0; i < `ALU_DW; i++) begin
            src[i] = left ? d[`ALU_DW-1-i] : d[i];
        end
        sh = src;
        for (int s = 0; s < `ALU_SW; s++) begin  // log2 stages
            if (amount[s]) begin
                sh = (sh >> (1 << s)) | (fill ? ~(ONES >> (1 << s)) : '0);
            end
        end
        for (int i = 0; i < `ALU_DW; i++) begin
            r[i] = left ? sh[`ALU_DW-1-i] : sh[i];  // undo the reversal
        end
    end

endmodule

// File: source/alu_mul_unit.sv
// two-stage pipelined unsigned multiplier, start strobe in and done strobe out after two edges
`timescale 1ns/1ps
`include "alu_ext_config.svh"

module alu_mul_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  alu_ext_pkg::data_t a,
    input  alu_ext_pkg::data_t b,
    output logic               done,
    output alu_ext_pkg::data_t lo,
    output alu_ext_pkg::data_t hi
);
    import alu_ext_pkg::*;

    localparam int HW = `ALU_DW / 2;        // half word

    data_t pp_ll, pp_lh, pp_hl, pp_hh;      // stage 1 partial products
    logic  v1;                              // stage 1 valid
    logic [2*`ALU_DW-1:0] prod;             // stage 2 sum

    // valid travels with the data
    always_ff @(posedge clk) begin
        if (rst) begin
            v1   <= 1'b0;
            done <= 1'b0;
        end else begin
            v1   <= start;
            done <= v1;
        end
    end

    always_ff @(posedge clk) begin
        pp_ll <= a[HW-1:0]       * b[HW-1:0];
        pp_lh <= a[HW-1:0]       * b[`ALU_DW-1:HW];
        pp_hl <= a[`ALU_DW-1:HW] * b[HW-1:0];
        pp_hh <= a[`ALU_DW-1:HW] * b[`ALU_DW-1:HW];
    end

    assign prod = {pp_hh, pp_ll}
                + {{HW{1'b0}}, pp_lh, {HW{1'b0}}}   // cross terms at half offset
                + {{HW{1'b0}}, pp_hl, {HW{1'b0}}};

    always_ff @(posedge clk) begin
        {hi, lo} <= prod;
    end

endmodule

// File: source/alu_div_unit.sv
// iterative restoring radix-2 unsigned divider, one quotient bit per cycle, flags a zero divisor
`timescale 1ns/1ps
`include "alu_ext_config.svh"

module alu_div_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  alu_ext_pkg::data_t x,
    input  alu_ext_pkg::data_t y,
    output logic               busy,
    output logic               done,
    output logic               dz,
    output alu_ext_pkg::data_t q,
    output alu_ext_pkg::data_t r
);
    import alu_ext_pkg::*;

    localparam int            CW   = $clog2(`ALU_DIV_ITER);
    localparam logic [CW-1:0] LAST = CW'(`ALU_DIV_ITER - 1);

    logic [`ALU_DW:0] acc;                  // partial remainder, one bit wider
    logic [`ALU_DW:0] acc_sh;               // after shifting in next dividend bit
    logic [`ALU_DW:0] acc_sub;              // trial subtraction
    logic             fits;                 // divisor goes into acc_sh
    data_t            qr;                   // dividend out at top, quotient in at bottom
    data_t            yreg;                 // held divisor
    logic [CW-1:0]    cnt;                  // iteration counter

    assign acc_sh  = {acc[`ALU_DW-1:0], qr[`ALU_DW-1]};
    assign fits    = acc_sh >= {1'b0, yreg};
    assign acc_sub = acc_sh - {1'b0, yreg};

    assign q = qr;
    assign r = acc[`ALU_DW-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            dz   <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                dz   <= (y == '0);
                done <= (y == '0);          // zero divisor ends right away
                busy <= (y != '0);
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST) begin      // last quotient bit
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            yreg <= y;
            qr   <= (y == '0) ? '1 : x;             // all ones on div by zero
            acc  <= (y == '0) ? {1'b0, x} : '0;     // remainder = dividend on dz
        end else if (busy) begin
            acc <= fits ? acc_sub : acc_sh;         // restore by keeping the shift
            qr  <= {qr[`ALU_DW-2:0], fits};
        end
    end

    // controller must wait for the result before a new divide
    a_no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

// File: source/alu_csr.sv
// config and status registers of the ALU: shift mode, result counter, sticky div-by-zero flag
`timescale 1ns/1ps
`include "alu_ext_config.svh"

module alu_csr (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cfg_we,
    input  alu_ext_pkg::csr_addr_e cfg_addr,
    input  alu_ext_pkg::data_t     cfg_wdata,
    output alu_ext_pkg::data_t     cfg_rdata,
    input  logic                   res_fire,
    input  logic                   dz_fire,
    output logic                   shift_arith
);
    import alu_ext_pkg::*;

    data_t count;                           // delivered results
    logic  dz_flag;                         // sticky

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_arith <= 1'b0;
            count       <= '0;
            dz_flag     <= 1'b0;
        end else begin
            if (cfg_we && cfg_addr == CSR_CTRL) begin
                shift_arith <= cfg_wdata[0];
            end
            if (res_fire) begin
                count <= count + 1'b1;      // wraps, no saturation
            end
            if (dz_fire) begin
                dz_flag <= 1'b1;            // set beats clear
            end else if (cfg_we && cfg_addr == CSR_STATUS) begin
                dz_flag <= 1'b0;            // any write clears
            end
        end
    end

    // read mux
    always_comb begin
        case (cfg_addr)
            CSR_CTRL:   cfg_rdata = {{(`ALU_DW-1){1'b0}}, shift_arith};
            CSR_COUNT:  cfg_rdata = count;
            CSR_STATUS: cfg_rdata = {{(`ALU_DW-1){1'b0}}, dz_flag};
            default:    cfg_rdata = '0;     // unmapped
        endcase
    end

endmodule

// File: source/alu_ext_ctrl.sv
// request/result controller of the ALU: accepts one op, starts its unit, holds the result
`timescale 1ns/1ps

module alu_ext_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  alu_ext_pkg::alu_op_e in_op,
    input  alu_ext_pkg::data_t   in_a,
    input  alu_ext_pkg::data_t   in_b,
    output logic                 out_valid,
    input  logic                 out_ready,
    output alu_ext_pkg::data_t   out_lo,
    output alu_ext_pkg::data_t   out_hi,
    output logic                 out_dz,
    output alu_ext_pkg::data_t   op_a,
    output alu_ext_pkg::data_t   op_b,
    output logic                 shift_left,
    input  alu_ext_pkg::data_t   shift_res,
    output logic                 mul_start,
    input  logic                 mul_done,
    input  alu_ext_pkg::data_t   mul_lo,
    input  alu_ext_pkg::data_t   mul_hi,
    output logic                 div_start,
    input  logic                 div_done,
    input  alu_ext_pkg::data_t   div_q,
    input  alu_ext_pkg::data_t   div_r,
    input  logic                 div_dz,
    output logic                 res_fire,
    output logic                 dz_fire
);
    import alu_ext_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,                             // ready for a request
        S_WAIT,                             // unit busy
        S_HOLD                              // result offered
    } state_e;

    state_e  state;
    alu_op_e op_q;                          // accepted opcode
    logic    accept;
    logic    unit_done;                     // selected unit has a result
    data_t   nxt_lo, nxt_hi;
    logic    nxt_dz;

    assign in_ready   = (state == S_IDLE);
    assign accept     = in_valid && in_ready;
    assign shift_left = (op_q == OP_SHL);
    assign res_fire   = out_valid && out_ready;
    assign dz_fire    = res_fire && out_dz;

    // result select by opcode
    always_comb begin
        unit_done = 1'b1;                   // shifter answers at once
        nxt_lo    = shift_res;
        nxt_hi    = '0;
        nxt_dz    = 1'b0;
        case (op_q)
            OP_MUL: begin
                unit_done = mul_done;
                nxt_lo    = mul_lo;
                nxt_hi    = mul_hi;
            end
            OP_DIV: begin
                unit_done = div_done;
                nxt_lo    = div_q;
                nxt_hi    = div_r;
                nxt_dz    = div_dz;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            out_valid <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= accept && (in_op == OP_MUL);   // one cycle strobes
            div_start <= accept && (in_op == OP_DIV);
            case (state)
                S_IDLE: if (accept) state <= S_WAIT;
                S_WAIT: if (unit_done) begin
                    state     <= S_HOLD;
                    out_valid <= 1'b1;
                end
                S_HOLD: if (out_ready) begin            // transfer
                    state     <= S_IDLE;
                    out_valid <= 1'b0;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= in_op;
            op_a <= in_a;
            op_b <= in_b;
        end
        if (state == S_WAIT && unit_done) begin
            out_lo <= nxt_lo;
            out_hi <= nxt_hi;
            out_dz <= nxt_dz;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid);

    a_one_start: assert property (@(posedge clk) disable iff (rst)
        !(mul_start && div_start));

endmodule

// File: source/alu_ext_top.sv
// top of the external ALU: controller, shifter, multiplier, divider and CSR block
`timescale 1ns/1ps
`include "alu_ext_config.svh"

module alu_ext_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  alu_ext_pkg::alu_op_e   in_op,
    input  alu_ext_pkg::data_t     in_a,
    input  alu_ext_pkg::data_t     in_b,
    output logic                   out_valid,
    input  logic                   out_ready,
    output alu_ext_pkg::data_t     out_lo,
    output alu_ext_pkg::data_t     out_hi,
    output logic                   out_dz,
    input  logic                   cfg_we,
    input  alu_ext_pkg::csr_addr_e cfg_addr,
    input  alu_ext_pkg::data_t     cfg_wdata,
    output alu_ext_pkg::data_t     cfg_rdata
);
    import alu_ext_pkg::*;

    data_t op_a, op_b;                      // held operands
    data_t shift_res, mul_lo, mul_hi, div_q, div_r;
    logic  shift_left, shift_arith;
    logic  mul_start, mul_done;
    logic  div_start, div_done, div_dz;
    logic  res_fire, dz_fire;

    alu_ext_ctrl u_ctrl (
        .clk, .rst,
        .in_valid, .in_ready, .in_op, .in_a, .in_b,
        .out_valid, .out_ready, .out_lo, .out_hi, .out_dz,
        .op_a, .op_b, .shift_left, .shift_res,
        .mul_start, .mul_done, .mul_lo, .mul_hi,
        .div_start, .div_done, .div_q, .div_r, .div_dz,
        .res_fire, .dz_fire
    );

    alu_shift_unit u_shift (
        .d      (op_a),
        .amount (op_b[`ALU_SW-1:0]),        // low bits of b
        .left   (shift_left),
        .arith  (shift_arith),
        .r      (shift_res)
    );

    alu_mul_unit u_mul (
        .clk, .rst,
        .start (mul_start),
        .a     (op_a),
        .b     (op_b),
        .done  (mul_done),
        .lo    (mul_lo),
        .hi    (mul_hi)
    );

    alu_div_unit u_div (
        .clk, .rst,
        .start (div_start),
        .x     (op_a),
        .y     (op_b),
        .busy  (),                          // controller tracks its own state
        .done  (div_done),
        .dz    (div_dz),
        .q     (div_q),
        .r     (div_r)
    );

    alu_csr u_csr (
        .clk, .rst,
        .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .res_fire, .dz_fire,
        .shift_arith
    );

endmodule

// File: sim/tb_clock_gen.sv
// testbench clock and reset source, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 8,           // clock period
    parameter int RST_CYCLES = 3            // reset length in clocks
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);  // seen by three rising edges
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: sim/alu_ext_tb.sv
// table-driven testbench of the external ALU, run as top module alu_ext_tb
`timescale 1ns/1ps

module alu_ext_tb;
    import alu_ext_pkg::*;

    localparam int NUM_TESTS  = 18;
    localparam int MAX_CYCLES = NUM_TESTS * 60 + 100;   // divide plus stalls per entry

    logic      clk, rst;
    logic      in_valid, in_ready, out_valid, out_ready, out_dz, cfg_we;
    alu_op_e   in_op;
    data_t     in_a, in_b, out_lo, out_hi, cfg_wdata, cfg_rdata;
    csr_addr_e cfg_addr;

    string   t_name  [NUM_TESTS];           // stimulus and expected columns
    logic    t_arith [NUM_TESTS];
    alu_op_e t_op    [NUM_TESTS];
    data_t   t_a     [NUM_TESTS];
    data_t   t_b     [NUM_TESTS];
    data_t   t_lo    [NUM_TESTS];
    data_t   t_hi    [NUM_TESTS];
    logic    t_dz    [NUM_TESTS];
    int      n_loaded;
    int      errors;
    int      checks;
    int      cycles = 0;

    tb_clock_gen clk_gen (.clk, .rst);

    alu_ext_top dut0 (
        .clk, .rst,
        .in_valid, .in_ready, .in_op, .in_a, .in_b,
        .out_valid, .out_ready, .out_lo, .out_hi, .out_dz,
        .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata
    );

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic add_entry(input string name, input logic arith, input alu_op_e op,
                             input data_t a, input data_t b, input data_t lo,
                             input data_t hi, input logic dz);
        t_name[n_loaded]  = name;
        t_arith[n_loaded] = arith;
        t_op[n_loaded]    = op;
        t_a[n_loaded]     = a;
        t_b[n_loaded]     = b;
        t_lo[n_loaded]    = lo;
        t_hi[n_loaded]    = hi;
        t_dz[n_loaded]    = dz;
        n_loaded++;
    endtask

    // name, arith, op, a, b, lo, hi, dz
    task automatic load_table();
        add_entry("shl_4",        0, OP_SHL, 32'h0000_0001, 32'd4,  32'h0000_0010, 0, 0);
        add_entry("shl_31",       0, OP_SHL, 32'h0000_0003, 32'd31, 32'h8000_0000, 0, 0);
        add_entry("shl_b_low",    0, OP_SHL, 32'h0000_00f0, 32'h21, 32'h0000_01e0, 0, 0);
        add_entry("shl_no_fill",  1, OP_SHL, 32'h8000_0001, 32'd1,  32'h0000_0002, 0, 0);
        add_entry("shr_log_4",    0, OP_SHR, 32'h8000_0010, 32'd4,  32'h0800_0001, 0, 0);
        add_entry("shr_ari_4",    1, OP_SHR, 32'h8000_0010, 32'd4,  32'hf800_0001, 0, 0);
        add_entry("shr_ari_0",    1, OP_SHR, 32'hf000_000f, 32'd0,  32'hf000_000f, 0, 0);
        add_entry("shr_ari_31",   1, OP_SHR, 32'h8000_0000, 32'd31, 32'hffff_ffff, 0, 0);
        add_entry("shr_log_31",   0, OP_SHR, 32'h8000_0000, 32'd31, 32'h0000_0001, 0, 0);
        add_entry("mul_small",    0, OP_MUL, 32'd6, 32'd7, 32'h0000_002a, 32'h0, 0);
        add_entry("mul_ones",     0, OP_MUL, '1, '1, 32'h0000_0001, 32'hffff_fffe, 0);
        add_entry("mul_shift",    0, OP_MUL, 32'h1234_5678, 32'h100, 32'h3456_7800, 32'h12, 0);
        add_entry("div_basic",    0, OP_DIV, 32'd100, 32'd7, 32'd14, 32'd2, 0);
        add_entry("div_small",    0, OP_DIV, 32'd5, 32'd9, 32'd0, 32'd5, 0);
        add_entry("div_zero_dvd", 0, OP_DIV, 32'd0, 32'd13, 32'd0, 32'd0, 0);
        add_entry("div_ones_16",  0, OP_DIV, '1, 32'h10, 32'h0fff_ffff, 32'hf, 0);
        add_entry("div_dz",       0, OP_DIV, 32'h1234_5678, 32'd0, '1, 32'h1234_5678, 1);
        add_entry("div_equal",    0, OP_DIV, '1, '1, 32'd1, 32'd0, 0);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR %s", what);
    endtask

    // callers sit on a falling edge, so do these tasks on return
    task automatic write_csr(input csr_addr_e addr, input data_t data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic read_csr(input csr_addr_e addr, output data_t data);
        cfg_addr = addr;
        @(negedge clk);                     // nothing moves the registers while idle
        data = cfg_rdata;
    endtask

    task automatic send_request(input int idx);
        in_valid = 1'b1;
        in_op    = t_op[idx];
        in_a     = t_a[idx];
        in_b     = t_b[idx];
        while (!in_ready) @(negedge clk);   // timeout covers a stuck port
        @(negedge clk);                     // accepted on the edge between
        in_valid = 1'b0;
    endtask

    task automatic collect_result(input int idx);
        logic  seen;
        logic  taken;
        data_t held_lo;
        data_t held_hi;
        logic  held_dz;
        seen  = 1'b0;
        taken = 1'b0;
        while (!taken) begin
            if (in_ready) begin
                report_error({t_name[idx], ": in_ready high while a result is pending"});
            end
            if (seen && !out_valid) begin
                report_error({t_name[idx], ": out_valid dropped before the transfer"});
            end else if (seen && {out_lo, out_hi, out_dz} !== {held_lo, held_hi, held_dz}) begin
                report_error({t_name[idx], ": result changed while stalled"});
            end
            if (out_valid && !seen) begin   // first offer, keep a copy
                seen    = 1'b1;
                held_lo = out_lo;
                held_hi = out_hi;
                held_dz = out_dz;
            end
            out_ready = ($urandom % 3) != 0;    // stall about one cycle in three
            if (out_valid && out_ready) begin
                check_data({t_name[idx], " lo"}, t_lo[idx], out_lo);
                check_data({t_name[idx], " hi"}, t_hi[idx], out_hi);
                check_flag({t_name[idx], " dz"}, t_dz[idx], out_dz);
                taken = 1'b1;
            end
            @(negedge clk);
        end
        out_ready = 1'b0;
        if (out_valid) begin
            report_error({t_name[idx], ": result offered again after the transfer"});
        end
        if (!in_ready) begin
            report_error({t_name[idx], ": in_ready still low after the transfer"});
        end
    endtask

    initial begin
        data_t rd;
        void'($urandom(32'h57db_2957));    // one seed for the whole run
        in_valid  = 1'b0;
        in_op     = OP_SHL;
        in_a      = '0;
        in_b      = '0;
        out_ready = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = CSR_CTRL;
        cfg_wdata = '0;
        errors    = 0;
        checks    = 0;
        n_loaded  = 0;
        load_table();
        @(negedge clk);
        while (rst) @(negedge clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            write_csr(CSR_CTRL, data_t'(t_arith[i]));
            send_request(i);
            collect_result(i);
            read_csr(CSR_STATUS, rd);       // flag follows the last result
            check_data({t_name[i], " status"}, data_t'(t_dz[i]), rd);
            if (t_dz[i]) begin
                write_csr(CSR_STATUS, '0);  // any write clears
                read_csr(CSR_STATUS, rd);
                check_data({t_name[i], " status cleared"}, '0, rd);
            end
        end
        read_csr(CSR_COUNT, rd);
        check_data("result count", data_t'(NUM_TESTS), rd);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+source
source/alu_ext_pkg.sv
source/alu_shift_unit.sv
source/alu_mul_unit.sv
source/alu_div_unit.sv
source/alu_csr.sv
source/alu_ext_ctrl.sv
source/alu_ext_top.sv
sim/tb_clock_gen.sv
sim/alu_ext_tb.sv

// File: Makefile
# Verilator build and run of the external ALU testbench

VERILATOR ?= verilator
TOP       ?= alu_ext_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
